// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary -j 0 -Wno-fatal -f all.f --top-module tb_decode_top -Mdir obj_dir
	./obj_dir/Vtb_decode_top | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== all.f ====
+incdir+dv
verilog/rv_isa_pkg.sv
verilog/decode_pkg.sv
verilog/fetch_queue.sv
verilog/compressed_expander.sv
verilog/instr_decoder.sv
verilog/id_issue_reg.sv
verilog/decode_top.sv
dv/tb_decode_top.sv

// ==== dv/tb_decode_ref.svh ====
// Reference RVC expansion, instruction encoders and decode model, included inside the decode testbench

// --------------------------------------------------
// 32-bit encoders, also used to build stimulus
// --------------------------------------------------
function automatic instr_t enc_i(input xlen_t imm, input reg_addr_t rs1, input funct3_t f3,
                                 input reg_addr_t rd, input opcode_t opc);
    return {imm[11:0], rs1, f3, rd, opc};
endfunction

function automatic instr_t enc_s(input xlen_t imm, input reg_addr_t rs2, input reg_addr_t rs1,
                                 input funct3_t f3, input opcode_t opc);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], opc};
endfunction

function automatic instr_t enc_b(input xlen_t imm, input reg_addr_t rs2, input reg_addr_t rs1);
    return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], OPC_BRANCH};
endfunction

function automatic instr_t enc_j(input xlen_t imm, input reg_addr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
endfunction

function automatic instr_t enc_r(input reg_addr_t rs2, input reg_addr_t rs1, input reg_addr_t rd);
    return {7'b0, rs2, rs1, 3'b000, rd, OPC_OP};
endfunction

// expansion of the supported rvc subset, offsets rebuilt from the rvc field maps
function automatic void ref_expand(input instr_t w, output instr_t x, output logic comp,
                                   output logic ill);
    creg_t     c;
    reg_addr_t rdp;
    reg_addr_t rs1p;
    xlen_t     uoff;
    c    = w[15:0];
    rdp  = {2'b01, c[4:2]};
    rs1p = {2'b01, c[9:7]};
    uoff = {25'b0, c[5], c[12:10], c[6], 2'b00};
    comp = (w[1:0] != 2'b11);
    ill  = 1'b0;
    x    = w;
    if (comp) begin
        x = '0;
        case ({c[15:13], c[1:0]})
            5'b010_00: x = enc_i(uoff, rs1p, 3'b010, rdp, OPC_LOAD);
            5'b110_00: x = enc_s(uoff, rdp, rs1p, 3'b010, OPC_STORE);
            5'b000_01: x = enc_i(xlen_t'($signed({c[12], c[6:2]})), c[11:7], 3'b000,
                                 c[11:7], OPC_OP_IMM);
            5'b010_01: x = enc_i(xlen_t'($signed({c[12], c[6:2]})), 5'd0, 3'b000,
                                 c[11:7], OPC_OP_IMM);
            5'b101_01: x = enc_j(xlen_t'($signed({c[12], c[8], c[10:9], c[6], c[7], c[2],
                                 c[11], c[5:3], 1'b0})), 5'd0);
            5'b110_01: x = enc_b(xlen_t'($signed({c[12], c[6:5], c[2], c[11:10], c[4:3],
                                 1'b0})), 5'd0, rs1p);
            5'b100_10: begin
                if (c[6:2] == 5'd0) ill = 1'b1;
                else if (c[12]) x = enc_r(c[6:2], c[11:7], c[11:7]);
                else x = enc_r(c[6:2], 5'd0, c[11:7]);
            end
            default: ill = 1'b1;
        endcase
    end
endfunction

// expected issue entry and control-flow flag for one fetch entry
function automatic void ref_decode(input xlen_t pc, input instr_t raw, output issue_entry_t e,
                                   output logic cf);
    instr_t w;
    logic   comp;
    logic   ill;
    ref_expand(raw, w, comp, ill);
    e               = '0;
    e.pc            = pc;
    e.is_compressed = comp;
    cf              = 1'b0;
    case (w[6:0])
        OPC_OP: begin
            e.fu  = ALU;
            e.rd  = w[11:7];
            e.rs1 = w[19:15];
            e.rs2 = w[24:20];
        end
        OPC_OP_IMM, OPC_LOAD, OPC_SYSTEM, OPC_JALR: begin
            e.rd  = w[11:7];
            e.rs1 = w[19:15];
            e.imm = xlen_t'($signed(w[31:20]));
            e.fu  = (w[6:0] == OPC_LOAD) ? LOAD : (w[6:0] == OPC_SYSTEM) ? CSR :
                    (w[6:0] == OPC_JALR) ? BRANCH : ALU;
            cf    = (w[6:0] == OPC_JALR);
        end
        OPC_STORE, OPC_BRANCH: begin
            e.rs1 = w[19:15];
            e.rs2 = w[24:20];
            cf    = (w[6:0] == OPC_BRANCH);
            e.fu  = cf ? BRANCH : STORE;
            e.imm = cf ? xlen_t'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}))
                       : xlen_t'($signed({w[31:25], w[11:7]}));
        end
        OPC_JAL: begin
            e.fu  = BRANCH;
            e.rd  = w[11:7];
            e.imm = xlen_t'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
            cf    = 1'b1;
        end
        OPC_LUI, OPC_AUIPC: begin
            e.fu  = ALU;
            e.rd  = w[11:7];
            e.imm = {w[31:12], 12'h0};
        end
        default: ill = 1'b1;
    endcase
    if (ill) begin
        e.illegal = 1'b1;
        e.fu      = NONE;
        cf        = 1'b0;
    end
endfunction

// ==== dv/tb_decode_top.sv ====
// Self-checking testbench for decode_top, run from all.f with the Makefile sim target
`timescale 1ns/1ps
`default_nettype none

module tb_decode_top import rv_isa_pkg::*; import decode_pkg::*; ();

    localparam int CLK_PERIOD  = 100;
    localparam int TEST_CYCLES = 400;
    localparam int STREAM_LEN  = 12;
    localparam int FETCH_DEPTH = 2;

    `include "tb_decode_ref.svh"

    typedef struct packed {
        issue_entry_t e;
        logic         cf;
    } exp_t;

    logic         clk_i;
    logic         rst_ni;
    logic         flush_i;
    logic         fetch_valid_i;
    fetch_entry_t fetch_entry_i;
    logic         fetch_ready_o;
    logic         issue_valid_o;
    issue_entry_t issue_entry_o;
    logic         is_ctrl_flow_o;
    logic         issue_ack_i;

    exp_t   sb[$];
    instr_t dir_q[$];
    integer seed;
    int     value_errs;
    int     other_errs;
    int     cycle;
    int     last_push_cycle;
    int     last_pop_cycle;
    int     t0;
    logic   last_accept;
    logic   saw_not_ready;
    logic   ack_level;
    logic   ack_random;

    decode_top #(.FETCH_DEPTH(FETCH_DEPTH), .RVC_EN(1'b1)) decode_top_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // ack is redrawn on each falling edge
    initial begin
        forever begin
            @(negedge clk_i);
            issue_ack_i = ack_random ? (($random(seed) & 3) == 0) : ack_level;
        end
    end

    // --------------------------------------------------
    // scoreboard, sampled 1 ns before each rising edge
    // --------------------------------------------------
    initial begin
        exp_t x;
        forever begin
            @(negedge clk_i);
            #(CLK_PERIOD / 2 - 1);
            cycle++;
            // queue is full exactly when it and the issue register hold depth + 1 entries
            if (rst_ni && fetch_ready_o !== (!flush_i && sb.size() < FETCH_DEPTH + 1)) begin
                value_errs++;
                $display("FAIL %0t: fetch ready %b with %0d entries in flight", $time,
                         fetch_ready_o, sb.size());
            end
            if (rst_ni && issue_valid_o && issue_ack_i) begin
                last_pop_cycle = cycle;
                if (sb.size() == 0) begin
                    other_errs++;
                    $display("output issued with no entry expected, pc %h", issue_entry_o.pc);
                end else begin
                    x = sb.pop_front();
                    if (issue_entry_o !== x.e || is_ctrl_flow_o !== x.cf) begin
                        value_errs++;
                        $display("FAIL %0t: pc %h got %h/%b expected %h/%b", $time,
                                 x.e.pc, issue_entry_o, is_ctrl_flow_o, x.e, x.cf);
                    end
                end
            end
            if (flush_i) sb.delete();
            if (rst_ni && !flush_i && !fetch_ready_o) saw_not_ready = 1'b1;
            last_accept = rst_ni && fetch_valid_i && fetch_ready_o;
            if (last_accept) begin
                ref_decode(fetch_entry_i.pc, fetch_entry_i.instr, x.e, x.cf);
                sb.push_back(x);
                last_push_cycle = cycle;
            end
        end
    end

    // holds the entry until the scoreboard saw it accepted
    task automatic send(input xlen_t pc, input instr_t w);
        fetch_valid_i = 1'b1;
        fetch_entry_i = '{pc: pc, instr: w};
        do @(negedge clk_i); while (!last_accept);
        fetch_valid_i = 1'b0;
    endtask

    task automatic drain();
        int n;
        n = 0;
        while ((sb.size() != 0 || issue_valid_o) && n < 100) begin
            @(negedge clk_i);
            n++;
        end
        if (n >= 100) begin
            other_errs++;
            $display("outputs still pending after 100 cycles");
        end
    endtask

    initial begin
        seed = 4;
        #(TEST_CYCLES * 4 * CLK_PERIOD + 5000);
        $display("watchdog expired before the tests finished");
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        rst_ni = 1'b0;
        flush_i = 1'b0;
        fetch_valid_i = 1'b0;
        fetch_entry_i = '0;
        issue_ack_i = 1'b0;
        ack_level = 1'b1;
        ack_random = 1'b0;
        value_errs = 0;
        other_errs = 0;
        cycle = 0;
        last_accept = 1'b0;
        saw_not_ready = 1'b0;
        repeat (8) @(negedge clk_i);
        rst_ni = 1'b1;
        @(negedge clk_i);
        if (issue_valid_o !== 1'b0 || fetch_ready_o !== 1'b1) begin
            other_errs++;
            $display("wrong handshake outputs after reset");
        end
        // one of each 32-bit class, then rvc forms and illegal words
        dir_q = '{enc_r(5'd3, 5'd2, 5'd1), enc_i(-32'sd5, 5'd4, 3'b000, 5'd6, OPC_OP_IMM),
                  enc_i(32'd40, 5'd7, 3'b010, 5'd8, OPC_LOAD),
                  enc_s(-32'sd12, 5'd9, 5'd10, 3'b010, OPC_STORE),
                  enc_b(-32'sd20, 5'd11, 5'd12), enc_j(32'h0000_1ffe, 5'd1),
                  enc_i(32'd16, 5'd13, 3'b000, 5'd0, OPC_JALR),
                  {20'habcde, 5'd14, OPC_LUI}, {20'h80001, 5'd15, OPC_AUIPC},
                  enc_i(32'h300, 5'd16, 3'b001, 5'd17, OPC_SYSTEM),
                  {16'h0, 3'b000, 1'b1, 5'd5, 5'b11101, 2'b01},
                  {16'h0, 3'b010, 1'b0, 5'd9, 5'b01010, 2'b01},
                  {16'h0, 3'b010, 3'b101, 3'd2, 1'b1, 1'b1, 3'd4, 2'b00},
                  {16'h0, 3'b110, 3'b011, 3'd5, 1'b0, 1'b1, 3'd1, 2'b00},
                  {16'h0, 3'b101, 11'h5a5, 2'b01}, {16'h0, 3'b110, 3'b101, 3'd3, 5'h13, 2'b01},
                  {16'h0, 4'b1000, 5'd10, 5'd11, 2'b10}, {16'h0, 4'b1001, 5'd12, 5'd13, 2'b10},
                  32'h0000_8082, 32'h0000_0000, 32'h0000_007f, 32'h0000_000b};
        foreach (dir_q[i]) send(32'h1000 + 4 * i, dir_q[i]);
        drain();
        // back-to-back stream, one output per cycle once full
        send(32'h2000, dir_q[0]);
        t0 = last_push_cycle;
        for (int i = 1; i < STREAM_LEN; i++) send(32'h2000 + 4 * i, dir_q[i]);
        drain();
        if (last_pop_cycle - t0 != STREAM_LEN + 1) begin
            other_errs++;
            $display("stream took %0d cycles instead of %0d", last_pop_cycle - t0,
                     STREAM_LEN + 1);
        end
        // random back-pressure with mixed words
        ack_random = 1'b1;
        for (int i = 0; i < 40; i++) begin
            if (i % 3 == 0) send(32'h3000 + 4 * i, $random(seed));
            else send(32'h3000 + 4 * i, dir_q[($random(seed) & 32'h7fff_ffff) % dir_q.size()]);
        end
        ack_random = 1'b0;
        drain();
        if (!saw_not_ready) begin
            other_errs++;
            $display("fetch ready never dropped under back-pressure");
        end
        // fill the pipeline, flush, then check that only new entries appear
        ack_level = 1'b0;
        for (int i = 0; i < 3; i++) send(32'h4000 + 4 * i, dir_q[i]);
        flush_i = 1'b1;
        @(negedge clk_i);
        flush_i = 1'b0;
        ack_level = 1'b1;
        for (int i = 0; i < 4; i++) send(32'h5000 + 4 * i, dir_q[i + 10]);
        drain();
        repeat (4) @(negedge clk_i);
        if (sb.size() != 0) begin
            other_errs++;
            $display("%0d expected entries never came out", sb.size());
        end
        $display("errors: %0d value, %0d other", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/compressed_expander.sv ====
// Detects 16-bit instructions and expands the supported RVC subset into 32-bit words before decode
`timescale 1ns/1ps
`default_nettype none

module compressed_expander import rv_isa_pkg::*; #(
    parameter bit RVC_EN = 1'b1
) (
    input  instr_t instr_i,
    output instr_t instr_o,
    output logic   is_compressed_o,
    output logic   illegal_o
);

    logic is_c;

    // anything but 2'b11 in the low bits is a 16-bit instruction
    assign is_c = (instr_i[1:0] != 2'b11);

    if (RVC_EN) begin : g_rvc
        creg_t     c;
        reg_addr_t rd_p;
        reg_addr_t rs1_p;
        instr_t    instr_exp;
        logic      illegal_exp;

        assign c     = instr_i[15:0];
        // three-bit register fields map onto x8..x15
        assign rd_p  = {2'b01, c[4:2]};
        assign rs1_p = {2'b01, c[9:7]};

        // ----------------------------------------------
        // expansion, keyed on funct3 and quadrant
        // ----------------------------------------------
        always_comb begin
            instr_exp   = '0;
            illegal_exp = 1'b0;
            case ({c[15:13], c[1:0]})
                // c.lw  lw rd', uimm(rs1')
                {3'b010, C_Q0}: begin
                    instr_exp = {5'b0, c[5], c[12:10], c[6], 2'b00, rs1_p, F3_LW, rd_p,
                                 OPC_LOAD};
                end
                // c.sw  sw rs2', uimm(rs1'), offset split over the S fields
                {3'b110, C_Q0}: begin
                    instr_exp = {5'b0, c[5], c[12], rd_p, rs1_p, F3_SW, c[11:10], c[6],
                                 2'b00, OPC_STORE};
                end
                // c.addi  addi rd, rd, imm
                {3'b000, C_Q1}: begin
                    instr_exp = {{6{c[12]}}, c[12], c[6:2], c[11:7], F3_ADD, c[11:7],
                                 OPC_OP_IMM};
                end
                // c.li  addi rd, x0, imm
                {3'b010, C_Q1}: begin
                    instr_exp = {{6{c[12]}}, c[12], c[6:2], 5'b0, F3_ADD, c[11:7],
                                 OPC_OP_IMM};
                end
                // c.j  jal x0, offset, bits reshuffled into the J layout
                {3'b101, C_Q1}: begin
                    instr_exp = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3],
                                 c[12], {8{c[12]}}, 5'b0, OPC_JAL};
                end
                // c.beqz  beq rs1', x0, offset
                {3'b110, C_Q1}: begin
                    instr_exp = {{4{c[12]}}, c[6:5], c[2], 5'b0, rs1_p, F3_BEQ, c[11:10],
                                 c[4:3], c[12], OPC_BRANCH};
                end
                // c.mv and c.add, rs2 of x0 would be c.jr / c.jalr / c.ebreak
                {3'b100, C_Q2}: begin
                    if (c[6:2] == 5'b0) begin
                        illegal_exp = 1'b1;
                    end else if (c[12]) begin
                        instr_exp = {7'b0, c[6:2], c[11:7], F3_ADD, c[11:7], OPC_OP};
                    end else begin
                        instr_exp = {7'b0, c[6:2], 5'b0, F3_ADD, c[11:7], OPC_OP};
                    end
                end
                // rest of the compressed space is not supported
                default: illegal_exp = 1'b1;
            endcase
        end

        assign instr_o         = is_c ? instr_exp : instr_i;
        assign is_compressed_o = is_c;
        assign illegal_o       = is_c && illegal_exp;
    end else begin : g_no_rvc
        // without RVC a 16-bit pattern is just an illegal word
        assign instr_o         = instr_i;
        assign is_compressed_o = 1'b0;
        assign illegal_o       = is_c;
    end

endmodule

`default_nettype wire

// ==== verilog/decode_pkg.sv ====
// Pipeline entry structs and functional unit codes shared by the fetch queue, decoder and issue register
`default_nettype none

package decode_pkg;

    import rv_isa_pkg::*;

    // --------------------------------------------------
    // functional units an instruction is steered to
    // --------------------------------------------------
    // NONE is used for illegal instructions
    typedef enum logic [2:0] {
        NONE   = 3'd0,
        ALU    = 3'd1,
        BRANCH = 3'd2,
        LOAD   = 3'd3,
        STORE  = 3'd4,
        CSR    = 3'd5
    } fu_t;

    // --------------------------------------------------
    // fetch side entry, 64 bits
    // --------------------------------------------------
    typedef struct packed {
        // address of the instruction
        xlen_t  pc;
        // raw word, compressed forms sit in the low half
        instr_t instr;
    } fetch_entry_t;

    // --------------------------------------------------
    // decoded entry handed to the issue stage
    // --------------------------------------------------
    typedef struct packed {
        xlen_t     pc;
        fu_t       fu;
        // unused register fields read as x0
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        // sign-extended immediate, zero for R-type
        xlen_t     imm;
        // came in as a 16-bit instruction
        logic      is_compressed;
        logic      illegal;
    } issue_entry_t;

endpackage

`default_nettype wire

// ==== verilog/decode_top.sv ====
// Decode stage top level: fetch queue, RVC expander, decoder and ID/issue register in a chain
`timescale 1ns/1ps
`default_nettype none

module decode_top import rv_isa_pkg::*; import decode_pkg::*; #(
    parameter int unsigned FETCH_DEPTH = 2,
    parameter bit          RVC_EN      = 1'b1
) (
    input  logic         clk_i,
    input  logic         rst_ni,
    input  logic         flush_i,
    // fetch handshake
    input  logic         fetch_valid_i,
    input  fetch_entry_t fetch_entry_i,
    output logic         fetch_ready_o,
    // issue handshake, ack is the ready
    output logic         issue_valid_o,
    output issue_entry_t issue_entry_o,
    output logic         is_ctrl_flow_o,
    input  logic         issue_ack_i
);

    logic         q_valid;
    logic         q_ready;
    fetch_entry_t q_entry;
    instr_t       exp_instr;
    logic         exp_compressed;
    logic         exp_illegal;
    issue_entry_t dec_entry;
    logic         dec_ctrl_flow;

    fetch_queue #(
        .FETCH_DEPTH ( FETCH_DEPTH )
    ) fetch_queue_i (
        .clk_i       ( clk_i         ),
        .rst_ni      ( rst_ni        ),
        .flush_i     ( flush_i       ),
        .in_valid_i  ( fetch_valid_i ),
        .in_entry_i  ( fetch_entry_i ),
        .in_ready_o  ( fetch_ready_o ),
        .out_valid_o ( q_valid       ),
        .out_entry_o ( q_entry       ),
        .out_ready_i ( q_ready       )
    );

    // expand and decode the queue head in the same cycle
    compressed_expander #(
        .RVC_EN ( RVC_EN )
    ) compressed_expander_i (
        .instr_i         ( q_entry.instr  ),
        .instr_o         ( exp_instr      ),
        .is_compressed_o ( exp_compressed ),
        .illegal_o       ( exp_illegal    )
    );

    instr_decoder instr_decoder_i (
        .pc_i            ( q_entry.pc     ),
        .instr_i         ( exp_instr      ),
        .is_compressed_i ( exp_compressed ),
        .illegal_i       ( exp_illegal    ),
        .entry_o         ( dec_entry      ),
        .is_ctrl_flow_o  ( dec_ctrl_flow  )
    );

    id_issue_reg id_issue_reg_i (
        .clk_i          ( clk_i          ),
        .rst_ni         ( rst_ni         ),
        .flush_i        ( flush_i        ),
        .in_valid_i     ( q_valid        ),
        .in_entry_i     ( dec_entry      ),
        .in_ctrl_flow_i ( dec_ctrl_flow  ),
        .in_ready_o     ( q_ready        ),
        .issue_valid_o  ( issue_valid_o  ),
        .issue_entry_o  ( issue_entry_o  ),
        .is_ctrl_flow_o ( is_ctrl_flow_o ),
        .issue_ack_i    ( issue_ack_i    )
    );

endmodule

`default_nettype wire

// ==== verilog/fetch_queue.sv ====
// Circular FIFO of fetch entries between fetch and decode, with valid/ready on both sides and flush
`timescale 1ns/1ps
`default_nettype none

module fetch_queue import decode_pkg::*; #(
    parameter int unsigned FETCH_DEPTH = 2
) (
    input  logic         clk_i,
    input  logic         rst_ni,
    input  logic         flush_i,
    // from fetch
    input  logic         in_valid_i,
    input  fetch_entry_t in_entry_i,
    output logic         in_ready_o,
    // towards expander and decoder
    output logic         out_valid_o,
    output fetch_entry_t out_entry_o,
    input  logic         out_ready_i
);

    localparam int unsigned PTR_W = $clog2(FETCH_DEPTH);
    localparam int unsigned CNT_W = $clog2(FETCH_DEPTH + 1);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] cnt_t;

    // storage only, valid entries are tracked by the count
    fetch_entry_t mem_q [FETCH_DEPTH];
    ptr_t         wr_ptr_q;
    ptr_t         rd_ptr_q;
    cnt_t         count_q;
    logic         full;
    logic         push;
    logic         pop;

    // wrap explicitly so that depths other than a power of two work
    function automatic ptr_t ptr_inc(input ptr_t ptr);
        return (ptr == ptr_t'(FETCH_DEPTH - 1)) ? '0 : ptr + ptr_t'(1);
    endfunction

    assign full        = (count_q == cnt_t'(FETCH_DEPTH));
    // nothing is taken in during a flush cycle
    assign in_ready_o  = !full && !flush_i;
    assign out_valid_o = (count_q != '0);
    // head entry is read straight out of the array
    assign out_entry_o = mem_q[rd_ptr_q];

    assign push = in_valid_i && in_ready_o;
    assign pop  = out_valid_o && out_ready_i;

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= in_entry_i;
        end
    end

    // --------------------------------------------------
    // pointers and occupancy
    // --------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            // push and pop together leave the count alone
            if (push && !pop) begin
                count_q <= count_q + cnt_t'(1);
            end else if (pop && !push) begin
                count_q <= count_q - cnt_t'(1);
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/id_issue_reg.sv ====
// One-entry ID/issue pipeline register that holds a decoded entry until the issue stage acknowledges it
`timescale 1ns/1ps
`default_nettype none

module id_issue_reg import decode_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_ni,
    input  logic         flush_i,
    // from the decoder
    input  logic         in_valid_i,
    input  issue_entry_t in_entry_i,
    input  logic         in_ctrl_flow_i,
    output logic         in_ready_o,
    // to the issue stage
    output logic         issue_valid_o,
    output issue_entry_t issue_entry_o,
    output logic         is_ctrl_flow_o,
    input  logic         issue_ack_i
);

    typedef struct packed {
        logic         valid;
        issue_entry_t entry;
        logic         ctrl_flow;
    } issue_reg_t;

    issue_reg_t reg_d;
    issue_reg_t reg_q;

    // room when empty or when the held entry leaves this cycle
    assign in_ready_o = (!reg_q.valid || issue_ack_i) && !flush_i;

    always_comb begin
        reg_d = reg_q;
        if (issue_ack_i) begin
            reg_d.valid = 1'b0;
        end
        if (in_valid_i && in_ready_o) begin
            reg_d = '{valid: 1'b1, entry: in_entry_i, ctrl_flow: in_ctrl_flow_i};
        end
        // flush wins over everything
        if (flush_i) begin
            reg_d.valid = 1'b0;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            reg_q <= '0;
        end else begin
            reg_q <= reg_d;
        end
    end

    assign issue_valid_o  = reg_q.valid;
    assign issue_entry_o  = reg_q.entry;
    assign is_ctrl_flow_o = reg_q.ctrl_flow;

endmodule

`default_nettype wire

// ==== verilog/instr_decoder.sv ====
// Combinational decode of an expanded 32-bit instruction into an issue entry for the ID/issue register
`timescale 1ns/1ps
`default_nettype none

module instr_decoder import rv_isa_pkg::*; import decode_pkg::*; (
    input  xlen_t        pc_i,
    input  instr_t       instr_i,
    input  logic         is_compressed_i,
    input  logic         illegal_i,
    output issue_entry_t entry_o,
    output logic         is_ctrl_flow_o
);

    opcode_t   opcode;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    xlen_t     imm_i_type;
    xlen_t     imm_s_type;
    xlen_t     imm_b_type;
    xlen_t     imm_u_type;
    xlen_t     imm_j_type;
    logic      unknown_opc;
    logic      ctrl_flow;

    assign opcode = instr_i[6:0];
    assign rd     = instr_i[11:7];
    assign rs1    = instr_i[19:15];
    assign rs2    = instr_i[24:20];

    // --------------------------------------------------
    // immediate formats, all sign-extended from bit 31
    // --------------------------------------------------
    assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                         instr_i[11:8], 1'b0};
    assign imm_u_type = {instr_i[31:12], 12'b0};
    assign imm_j_type = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                         instr_i[30:21], 1'b0};

    // --------------------------------------------------
    // per-opcode unit, register and immediate selection
    // --------------------------------------------------
    always_comb begin
        entry_o               = '0;
        entry_o.pc            = pc_i;
        entry_o.is_compressed = is_compressed_i;
        unknown_opc           = 1'b0;
        ctrl_flow             = 1'b0;

        case (opcode)
            // register-register, no immediate
            OPC_OP: begin
                entry_o.fu  = ALU;
                entry_o.rd  = rd;
                entry_o.rs1 = rs1;
                entry_o.rs2 = rs2;
            end
            OPC_OP_IMM: begin
                entry_o.fu  = ALU;
                entry_o.rd  = rd;
                entry_o.rs1 = rs1;
                entry_o.imm = imm_i_type;
            end
            OPC_LOAD: begin
                entry_o.fu  = LOAD;
                entry_o.rd  = rd;
                entry_o.rs1 = rs1;
                entry_o.imm = imm_i_type;
            end
            // stores write no register
            OPC_STORE: begin
                entry_o.fu  = STORE;
                entry_o.rs1 = rs1;
                entry_o.rs2 = rs2;
                entry_o.imm = imm_s_type;
            end
            OPC_BRANCH: begin
                entry_o.fu  = BRANCH;
                entry_o.rs1 = rs1;
                entry_o.rs2 = rs2;
                entry_o.imm = imm_b_type;
                ctrl_flow   = 1'b1;
            end
            // jumps go to the branch unit and write the link register
            OPC_JAL: begin
                entry_o.fu  = BRANCH;
                entry_o.rd  = rd;
                entry_o.imm = imm_j_type;
                ctrl_flow   = 1'b1;
            end
            OPC_JALR: begin
                entry_o.fu  = BRANCH;
                entry_o.rd  = rd;
                entry_o.rs1 = rs1;
                entry_o.imm = imm_i_type;
                ctrl_flow   = 1'b1;
            end
            OPC_LUI, OPC_AUIPC: begin
                entry_o.fu  = ALU;
                entry_o.rd  = rd;
                entry_o.imm = imm_u_type;
            end
            // csr access, immediate holds the csr address
            OPC_SYSTEM: begin
                entry_o.fu  = CSR;
                entry_o.rd  = rd;
                entry_o.rs1 = rs1;
                entry_o.imm = imm_i_type;
            end
            default: unknown_opc = 1'b1;
        endcase

        // illegal entries never reach a unit
        entry_o.illegal = illegal_i || unknown_opc;
        if (entry_o.illegal) begin
            entry_o.fu = NONE;
            ctrl_flow  = 1'b0;
        end
    end

    assign is_ctrl_flow_o = ctrl_flow;

endmodule

`default_nettype wire

// ==== verilog/rv_isa_pkg.sv ====
// ISA-level word types, base opcodes and compressed quadrant codes, imported by the decode RTL
`default_nettype none

package rv_isa_pkg;

    // --------------------------------------------------
    // word and field types
    // --------------------------------------------------
    // data or address word
    typedef logic [31:0] xlen_t;
    // full-width instruction word as fetched
    typedef logic [31:0] instr_t;
    // 16-bit compressed instruction, low half of a fetch word
    typedef logic [15:0] creg_t;
    // architectural register index
    typedef logic [4:0]  reg_addr_t;
    // major opcode field, instr[6:0]
    typedef logic [6:0]  opcode_t;
    // minor function field, also reused for the compressed funct3
    typedef logic [2:0]  funct3_t;
    // compressed quadrant, instr[1:0]
    typedef logic [1:0]  quadrant_t;

    // --------------------------------------------------
    // base opcodes (RV32I)
    // --------------------------------------------------
    localparam opcode_t OPC_OP     = 7'b011_0011;
    localparam opcode_t OPC_OP_IMM = 7'b001_0011;
    localparam opcode_t OPC_LOAD   = 7'b000_0011;
    localparam opcode_t OPC_STORE  = 7'b010_0011;
    localparam opcode_t OPC_BRANCH = 7'b110_0011;
    localparam opcode_t OPC_JAL    = 7'b110_1111;
    localparam opcode_t OPC_JALR   = 7'b110_0111;
    localparam opcode_t OPC_LUI    = 7'b011_0111;
    localparam opcode_t OPC_AUIPC  = 7'b001_0111;
    localparam opcode_t OPC_SYSTEM = 7'b111_0011;

    // funct3 values the expander writes into its 32-bit forms
    localparam funct3_t F3_ADD = 3'b000;
    localparam funct3_t F3_BEQ = 3'b000;
    localparam funct3_t F3_LW  = 3'b010;
    localparam funct3_t F3_SW  = 3'b010;

    // --------------------------------------------------
    // compressed quadrants, 2'b11 means a 32-bit word
    // --------------------------------------------------
    localparam quadrant_t C_Q0 = 2'b00;
    localparam quadrant_t C_Q1 = 2'b01;
    localparam quadrant_t C_Q2 = 2'b10;

endpackage

`default_nettype wire
